/* Bender.yml */
package:
  name: riscv_core

sources:
  - rtl/riscv_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/register_file.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/pipeline_control.sv
  - rtl/riscv_core.sv
  - target: test
    files:
      - tests/riscv_core_tb.sv

/* project.f */
rtl/riscv_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipeline_control.sv
rtl/riscv_core.sv
tests/riscv_core_tb.sv

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import riscv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic kill,
	input logic id_valid,
	input word_t id_inst,
	input word_t id_pc,
	input word_t rs1_val,
	input word_t rs2_val,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output exe_op_e exe_op,
	output reg_idx_t exe_rd,
	output word_t exe_pc,
	output word_t exe_offset,
	output word_t op_1,
	output word_t op_2,
	output reg_idx_t fwd_rs1,
	output reg_idx_t fwd_rs2
);

	opcode_e opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	exe_op_e alu_op, branch_op, op_next;
	reg_idx_t rd_next, fwd_rs1_next, fwd_rs2_next;
	word_t op_1_next, op_2_next, offset_next;
	logic swap;

	assign opcode = opcode_e'(id_inst[6:2]);
	assign funct3 = id_inst[14:12];
	assign funct7 = id_inst[31:25];
	assign rs1 = id_inst[19:15];
	assign rs2 = id_inst[24:20];

	assign imm_i = {{21{id_inst[31]}}, id_inst[30:20]};
	assign imm_s = {{21{id_inst[31]}}, id_inst[30:25], id_inst[11:7]};
	assign imm_b = {{20{id_inst[31]}}, id_inst[7], id_inst[30:25], id_inst[11:8], 1'b0};
	assign imm_u = {id_inst[31:12], 12'b0};
	assign imm_j = {{12{id_inst[31]}}, id_inst[19:12], id_inst[20], id_inst[30:21], 1'b0};

	always_comb begin
		case (funct3)
			3'b000: alu_op = (opcode == opc_op && funct7[5]) ? exe_sub : exe_add;
			3'b001: alu_op = exe_sll;
			3'b010: alu_op = exe_slt;
			3'b011: alu_op = exe_sltu;
			3'b100: alu_op = exe_xor;
			3'b101: alu_op = funct7[5] ? exe_sra : exe_srl;
			3'b110: alu_op = exe_or;
			3'b111: alu_op = exe_and;
		endcase
	end

	// bge and bgeu are blt and bltu with swapped operands
	assign swap = funct3[2] && funct3[0];

	always_comb begin
		case (funct3)
			3'b000: branch_op = exe_beq;
			3'b001: branch_op = exe_bne;
			3'b100, 3'b101: branch_op = exe_blt;
			3'b110, 3'b111: branch_op = exe_bltu;
			default: branch_op = exe_nop;
		endcase
	end

	always_comb begin
		op_next = exe_nop;
		rd_next = id_inst[11:7];
		op_1_next = rs1_val;
		op_2_next = rs2_val;
		offset_next = imm_i;
		fwd_rs1_next = rs1;
		fwd_rs2_next = rs2;
		if (id_inst[1:0] == 2'b11) begin
			case (opcode)
				opc_op_imm: begin
					op_next = alu_op;
					op_2_next = imm_i;
					fwd_rs2_next = '0;
				end
				opc_op: op_next = alu_op;
				opc_lui: begin
					op_next = exe_lui;
					op_1_next = imm_u;
					fwd_rs1_next = '0;
					fwd_rs2_next = '0;
				end
				opc_auipc: begin
					op_next = exe_add;
					op_1_next = id_pc;
					op_2_next = imm_u;
					fwd_rs1_next = '0;
					fwd_rs2_next = '0;
				end
				opc_jal: begin
					op_next = exe_jump;
					op_1_next = id_pc;
					op_2_next = imm_j;
					fwd_rs1_next = '0;
					fwd_rs2_next = '0;
				end
				opc_jalr: begin
					if (funct3 == 3'b000)
						op_next = exe_jump;
					op_2_next = imm_i;
					fwd_rs2_next = '0;
				end
				opc_branch: begin
					op_next = branch_op;
					rd_next = '0;
					offset_next = imm_b;
					if (swap) begin
						op_1_next = rs2_val;
						op_2_next = rs1_val;
						fwd_rs1_next = rs2;
						fwd_rs2_next = rs1;
					end
				end
				// Word access only
				opc_load: begin
					if (funct3 == 3'b010)
						op_next = exe_load;
					fwd_rs2_next = '0;
				end
				opc_store: begin
					if (funct3 == 3'b010)
						op_next = exe_store;
					rd_next = '0;
					offset_next = imm_s;
				end
				default: op_next = exe_nop;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset || kill || !id_valid)
			exe_op <= exe_nop;
		else
			exe_op <= op_next;
	end

	always_ff @(posedge clk) begin
		exe_rd <= rd_next;
		exe_pc <= id_pc;
		exe_offset <= offset_next;
		op_1 <= op_1_next;
		op_2 <= op_2_next;
		fwd_rs1 <= fwd_rs1_next;
		fwd_rs2 <= fwd_rs2_next;
	end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import riscv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic kill,
	input exe_op_e exe_op,
	input reg_idx_t exe_rd,
	input word_t exe_pc,
	input word_t exe_offset,
	input word_t op_1,
	input word_t op_2,
	input reg_idx_t fwd_rs1,
	input reg_idx_t fwd_rs2,
	input logic mem_fwd_en,
	input word_t mem_fwd,
	input logic rf_write_en,
	input reg_idx_t wb_rd,
	input word_t wb_data,
	output mem_op_e mem_op,
	output reg_idx_t mem_rd,
	output word_t mem_target,
	output word_t mem_res,
	output word_t mem_link
);

	word_t op_a, op_b, alu_res, addr;
	logic [4:0] shamt;
	logic cond;

	// Youngest producer wins and x0 never forwards
	function automatic word_t forward(reg_idx_t idx, word_t value);
		if (idx != '0 && mem_fwd_en && mem_rd == idx)
			return mem_fwd;
		if (idx != '0 && rf_write_en && wb_rd == idx)
			return wb_data;
		return value;
	endfunction

	always_comb begin
		op_a = forward(fwd_rs1, op_1);
		op_b = forward(fwd_rs2, op_2);
	end

	assign shamt = op_b[4:0];
	assign addr = op_a + exe_offset;

	always_comb begin
		case (exe_op)
			exe_sub: alu_res = op_a - op_b;
			exe_slt: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			exe_sltu: alu_res = {31'b0, op_a < op_b};
			exe_and: alu_res = op_a & op_b;
			exe_or: alu_res = op_a | op_b;
			exe_xor: alu_res = op_a ^ op_b;
			exe_sll: alu_res = op_a << shamt;
			exe_srl: alu_res = op_a >> shamt;
			exe_sra: alu_res = $signed(op_a) >>> shamt;
			exe_lui: alu_res = op_a;
			default: alu_res = op_a + op_b;
		endcase
	end

	always_comb begin
		case (exe_op)
			exe_beq: cond = (op_a == op_b);
			exe_bne: cond = (op_a != op_b);
			exe_blt: cond = $signed(op_a) < $signed(op_b);
			exe_bltu: cond = op_a < op_b;
			default: cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || kill) begin
			mem_op <= mem_nop;
		end else begin
			case (exe_op)
				exe_jump: mem_op <= mem_jump;
				exe_beq, exe_bne, exe_blt, exe_bltu: mem_op <= cond ? mem_jump : mem_nop;
				exe_load: mem_op <= mem_load;
				exe_store: mem_op <= mem_store;
				exe_nop: mem_op <= mem_nop;
				default: mem_op <= mem_forward;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		mem_rd <= exe_rd;
		mem_link <= exe_pc + 32'd4;
		mem_res <= (exe_op == exe_store) ? op_b : alu_res;
		case (exe_op)
			exe_jump: mem_target <= {alu_res[31:1], 1'b0};
			exe_beq, exe_bne, exe_blt, exe_bltu: mem_target <= exe_pc + exe_offset;
			default: mem_target <= addr;
		endcase
	end

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import riscv_pkg::*; #(
	parameter word_t reset_pc = 32'h0
) (
	input logic clk,
	input logic reset,
	input logic kill,
	input word_t redirect_pc,
	input word_t rom_data,
	output word_t rom_addr,
	output logic id_valid,
	output word_t id_inst,
	output word_t id_pc
);

	word_t pc;

	assign rom_addr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			id_valid <= 1'b0;
		end else if (kill) begin
			pc <= redirect_pc;
			id_valid <= 1'b0;
		end else begin
			pc <= pc + 32'd4;
			id_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		id_inst <= rom_data;
		id_pc <= pc;
	end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage import riscv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic kill,
	input mem_op_e mem_op,
	input reg_idx_t mem_rd,
	input word_t mem_target,
	input word_t mem_res,
	input word_t mem_link,
	input word_t ram_rdata,
	output word_t ram_addr,
	output word_t ram_wdata,
	output logic ram_write_en,
	output logic mem_fwd_en,
	output word_t mem_fwd,
	output wb_op_e wb_op,
	output reg_idx_t wb_rd,
	output word_t wb_res,
	output word_t wb_link
);

	assign ram_addr = mem_target;
	assign ram_wdata = mem_res;
	// Store in the shadow of a taken jump must not land
	assign ram_write_en = (mem_op == mem_store) && !kill;

	// RAM reads in the same cycle, so a load forwards like an ALU result
	assign mem_fwd_en = (mem_op == mem_forward || mem_op == mem_load);
	assign mem_fwd = (mem_op == mem_load) ? ram_rdata : mem_res;

	always_ff @(posedge clk) begin
		if (reset || kill) begin
			wb_op <= wb_nop;
		end else begin
			case (mem_op)
				mem_forward, mem_load: wb_op <= wb_write;
				mem_jump: wb_op <= wb_jump;
				default: wb_op <= wb_nop;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		wb_rd <= mem_rd;
		wb_res <= (mem_op == mem_jump) ? mem_target : mem_fwd;
		wb_link <= mem_link;
	end

	assert property (@(posedge clk) disable iff (reset)
		mem_op == mem_store |-> mem_target[1:0] == 2'b00);

endmodule

/* rtl/pipeline_control.sv */
`timescale 1ns/100ps

module pipeline_control import riscv_pkg::*; #(
	parameter word_t reset_pc = 32'h0
) (
	input logic clk,
	input logic reset,
	input wb_op_e wb_op,
	input reg_idx_t wb_rd,
	input word_t wb_res,
	input word_t wb_link,
	output logic rf_write_en,
	output logic kill,
	output word_t redirect_pc,
	output logic retire_en,
	output reg_idx_t retire_rd,
	output word_t retire_data
);

	// x0 is never written, so it never retires either
	assign rf_write_en = (wb_op == wb_write || wb_op == wb_jump) && wb_rd != '0;

	// Taken control transfer flushes the three younger slots
	assign kill = (wb_op == wb_jump);

	// Idle value is the reset vector
	assign redirect_pc = kill ? wb_res : reset_pc;

	assign retire_en = rf_write_en;
	assign retire_rd = wb_rd;
	// Jumps write the link, the target goes to fetch
	assign retire_data = (wb_op == wb_jump) ? wb_link : wb_res;

	// Reset empties every stage, so nothing can redirect right after it
	assert property (@(posedge clk) reset |=> !kill);

endmodule

/* rtl/register_file.sv */
`timescale 1ns/100ps

module register_file import riscv_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	input reg_idx_t rd,
	input word_t wdata,
	input logic write_en,
	output word_t rs1_val,
	output word_t rs2_val
);

	word_t regs [32];

	// Write-through so decode sees the value retiring this cycle
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (write_en && rd == idx)
			return wdata;
		return regs[idx];
	endfunction

	always_comb begin
		rs1_val = read_port(rs1);
		rs2_val = read_port(rs2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (write_en && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

/* rtl/riscv_core.sv */
`timescale 1ns/100ps

module riscv_core import riscv_pkg::*; #(
	parameter word_t reset_pc = 32'h0
) (
	input logic clk,
	input logic reset,
	output word_t rom_addr,
	input word_t rom_data,
	output word_t ram_addr,
	output word_t ram_wdata,
	output logic ram_write_en,
	input word_t ram_rdata,
	output logic retire_en,
	output reg_idx_t retire_rd,
	output word_t retire_data
);

	logic kill;
	word_t redirect_pc;
	logic rf_write_en;

	// Fetch to decode
	logic id_valid;
	word_t id_inst;
	word_t id_pc;

	// Register file read ports
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t rs1_val;
	word_t rs2_val;

	// Decode to execute
	exe_op_e exe_op;
	reg_idx_t exe_rd;
	word_t exe_pc;
	word_t exe_offset;
	word_t op_1;
	word_t op_2;
	reg_idx_t fwd_rs1;
	reg_idx_t fwd_rs2;

	// Execute to memory
	mem_op_e mem_op;
	reg_idx_t mem_rd;
	word_t mem_target;
	word_t mem_res;
	word_t mem_link;
	logic mem_fwd_en;
	word_t mem_fwd;

	// Memory to writeback
	wb_op_e wb_op;
	reg_idx_t wb_rd;
	word_t wb_res;
	word_t wb_link;

	fetch_stage #(.reset_pc(reset_pc)) fetch_stage_inst (
		.clk(clk), .reset(reset), .kill(kill), .redirect_pc(redirect_pc),
		.rom_data(rom_data), .rom_addr(rom_addr),
		.id_valid(id_valid), .id_inst(id_inst), .id_pc(id_pc)
	);

	decode_stage decode_stage_inst (
		.clk(clk), .reset(reset), .kill(kill),
		.id_valid(id_valid), .id_inst(id_inst), .id_pc(id_pc),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .rs1(rs1), .rs2(rs2),
		.exe_op(exe_op), .exe_rd(exe_rd), .exe_pc(exe_pc), .exe_offset(exe_offset),
		.op_1(op_1), .op_2(op_2), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
	);

	register_file register_file_inst (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
		.rd(retire_rd), .wdata(retire_data), .write_en(rf_write_en),
		.rs1_val(rs1_val), .rs2_val(rs2_val)
	);

	execute_stage execute_stage_inst (
		.clk(clk), .reset(reset), .kill(kill),
		.exe_op(exe_op), .exe_rd(exe_rd), .exe_pc(exe_pc), .exe_offset(exe_offset),
		.op_1(op_1), .op_2(op_2), .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2),
		.mem_fwd_en(mem_fwd_en), .mem_fwd(mem_fwd),
		.rf_write_en(rf_write_en), .wb_rd(wb_rd), .wb_data(retire_data),
		.mem_op(mem_op), .mem_rd(mem_rd), .mem_target(mem_target),
		.mem_res(mem_res), .mem_link(mem_link)
	);

	memory_stage memory_stage_inst (
		.clk(clk), .reset(reset), .kill(kill),
		.mem_op(mem_op), .mem_rd(mem_rd), .mem_target(mem_target),
		.mem_res(mem_res), .mem_link(mem_link), .ram_rdata(ram_rdata),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_write_en(ram_write_en),
		.mem_fwd_en(mem_fwd_en), .mem_fwd(mem_fwd),
		.wb_op(wb_op), .wb_rd(wb_rd), .wb_res(wb_res), .wb_link(wb_link)
	);

	pipeline_control #(.reset_pc(reset_pc)) pipeline_control_inst (
		.clk(clk), .reset(reset),
		.wb_op(wb_op), .wb_rd(wb_rd), .wb_res(wb_res), .wb_link(wb_link),
		.rf_write_en(rf_write_en), .kill(kill), .redirect_pc(redirect_pc),
		.retire_en(retire_en), .retire_rd(retire_rd), .retire_data(retire_data)
	);

endmodule

/* rtl/riscv_pkg.sv */
package riscv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// Major opcode, instruction bits 6 to 2
	typedef enum logic [4:0] {
		opc_load = 5'b00000,
		opc_op_imm = 5'b00100,
		opc_auipc = 5'b00101,
		opc_store = 5'b01000,
		opc_op = 5'b01100,
		opc_lui = 5'b01101,
		opc_branch = 5'b11000,
		opc_jalr = 5'b11001,
		opc_jal = 5'b11011
	} opcode_e;

	typedef enum logic [4:0] {
		exe_add, exe_sub, exe_slt, exe_sltu,
		exe_and, exe_or, exe_xor,
		exe_sll, exe_srl, exe_sra,
		exe_lui,
		exe_jump, exe_beq, exe_bne, exe_blt, exe_bltu,
		exe_load, exe_store,
		exe_nop
	} exe_op_e;

	typedef enum logic [2:0] {
		mem_forward, mem_jump, mem_load, mem_store, mem_nop
	} mem_op_e;

	typedef enum logic [1:0] {
		wb_write, wb_jump, wb_nop
	} wb_op_e;

endpackage

/* tests/program_input.mem */
// Program words from address 0, record count at 100, records from 101
// Record columns: tag (test, kind, 00, rd), a, b
// Kind 1 retires rd with a; kind 2 stores b at a; kind 3 retires rd with RAM word at a plus b
@000
123450B7 67800113 002081B3 FF000213 404102B3 0041F333 004163B3 0011C433
00411493 40225513 01C25593 00222633 002236B3 00001717 00100793 00F787B3
00F787B3 00F78833 010788B3 40F88933 04000993 0039A023 1489AA03 003A0AB3
0009AB03 00000B93 00210463 100B8B93 00410463 001B8B93 00411463 0179A023
00211463 001B8B93 00224463 100B8B93 00414463 001B8B93 00415463 100B8B93
00225463 001B8B93 00416463 100B8B93 00226463 001B8B93 00227463 100B8B93
00417463 001B8B93 00C00C6F 10000C93 20000C93 05500C93 018C0D67 30000C93
40000C93 001C8D93 0000006F 00000000 00000000 00000000
@100
00000024
// ALU and immediates
01010001 12345000 00000000
01010002 00000678 00000000
01010003 12345678 00000000
01010004 FFFFFFF0 00000000
01010005 00000688 00000000
01010006 12345670 00000000
01010007 FFFFFFF8 00000000
01010008 00000678 00000000
01010009 00006780 00000000
0101000A FFFFFFFC 00000000
0101000B 0000000F 00000000
0101000C 00000001 00000000
0101000D 00000000 00000000
0101000E 00001034 00000000
// Dependency chain
0201000F 00000001 00000000
0201000F 00000002 00000000
0201000F 00000004 00000000
02010010 00000008 00000000
02010011 0000000C 00000000
02010012 00000008 00000000
// Store then load
03010013 00000040 00000000
03020000 00000040 12345678
03030014 00000188 00000000
03030015 00000188 12345678
03010016 12345678 00000000
// Branches, fall-through counter only
04010017 00000000 00000000
04010017 00000001 00000000
04010017 00000002 00000000
04010017 00000003 00000000
04010017 00000004 00000000
04010017 00000005 00000000
04010017 00000006 00000000
// JAL and JALR
05010018 000000CC 00000000
05010019 00000055 00000000
0501001A 000000DC 00000000
0501001B 00000056 00000000

/* tests/riscv_core_tb.sv */
`timescale 1ns/100ps

module riscv_core_tb import riscv_pkg::*; ();

	// Data file layout in words
	localparam int count_index = 256;
	localparam int max_records = 64;

	logic clk;
	logic reset;
	word_t rom_addr;
	word_t rom_data;
	word_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;
	logic ram_write_en;
	logic retire_en;
	reg_idx_t retire_rd;
	word_t retire_data;

	word_t file_words [0:511];
	word_t ram [0:255];
	word_t rec_tag [0:max_records-1];
	word_t rec_a [0:max_records-1];
	word_t rec_b [0:max_records-1];
	int retire_q [$];
	int store_q [$];
	int remaining [1:6];
	int test_errors [1:6];
	int stray_errors;
	int checks;
	int timeouts;

	riscv_core #(.reset_pc(32'h0)) riscv_core_inst (
		.clk(clk), .reset(reset),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_write_en(ram_write_en),
		.ram_rdata(ram_rdata),
		.retire_en(retire_en), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	always #2 clk = ~clk;

	// ROM and RAM answer in the same cycle
	assign rom_data = file_words[rom_addr[9:2]];
	assign ram_rdata = ram[ram_addr[9:2]];

	always @(posedge clk) begin
		if (ram_write_en)
			ram[ram_addr[9:2]] <= ram_wdata;
	end

	function automatic string test_name(input int t);
		case (t)
			1: return "ALU and immediates";
			2: return "back-to-back dependencies";
			3: return "store then load";
			4: return "branches";
			5: return "JAL and JALR";
			6: return "reset state";
			default: return "unknown";
		endcase
	endfunction

	task automatic finish_record(input int t);
		remaining[t]--;
		if (remaining[t] == 0)
			$display("test %0d %s: done, %0d errors", t, test_name(t), test_errors[t]);
	endtask

	task automatic check_retire();
		int r;
		int t;
		word_t expected;
		if (retire_q.size() == 0) begin
			$display("unexpected retire of x%0d with %h after the last expected record",
				retire_rd, retire_data);
			stray_errors++;
			return;
		end
		r = retire_q.pop_front();
		t = rec_tag[r][31:24];
		// Kind 3 expects a RAM word plus an addend for a dependent add
		if (rec_tag[r][23:16] == 8'd3)
			expected = ram[rec_a[r][9:2]] + rec_b[r];
		else
			expected = rec_a[r];
		checks += 2;
		if (retire_rd !== rec_tag[r][4:0]) begin
			$display("error retire_rd: expected %h, got %h", rec_tag[r][4:0], retire_rd);
			test_errors[t]++;
		end
		if (retire_data !== expected) begin
			$display("error retire_data: expected %h, got %h", expected, retire_data);
			test_errors[t]++;
		end
		finish_record(t);
	endtask

	task automatic check_store();
		int r;
		int t;
		if (store_q.size() == 0) begin
			$display("unexpected store of %h to address %h", ram_wdata, ram_addr);
			stray_errors++;
			return;
		end
		r = store_q.pop_front();
		t = rec_tag[r][31:24];
		checks += 2;
		if (ram_addr !== rec_a[r]) begin
			$display("error ram_addr: expected %h, got %h", rec_a[r], ram_addr);
			test_errors[t]++;
		end
		if (ram_wdata !== rec_b[r]) begin
			$display("error ram_wdata: expected %h, got %h", rec_b[r], ram_wdata);
			test_errors[t]++;
		end
		finish_record(t);
	endtask

	always @(posedge clk) begin
		if (reset === 1'b0) begin
			if (retire_en)
				check_retire();
			if (ram_write_en)
				check_store();
		end
	end

	task automatic check_reset_state();
		checks += 3;
		if (rom_addr !== 32'h0) begin
			$display("error rom_addr: expected %h, got %h", 32'h0, rom_addr);
			test_errors[6]++;
		end
		if (ram_write_en !== 1'b0) begin
			$display("error ram_write_en: expected %h, got %h", 1'b0, ram_write_en);
			test_errors[6]++;
		end
		if (retire_en !== 1'b0) begin
			$display("error retire_en: expected %h, got %h", 1'b0, retire_en);
			test_errors[6]++;
		end
	endtask

	// Split records into retire and store queues in file order
	task automatic load_records();
		int count;
		int t;
		count = file_words[count_index];
		if (count < 1 || count > max_records) begin
			$display("record count %0d in the data file is out of range", count);
			stray_errors++;
			count = 0;
		end
		for (int i = 0; i < count; i++) begin
			rec_tag[i] = file_words[count_index + 1 + 3 * i];
			rec_a[i] = file_words[count_index + 2 + 3 * i];
			rec_b[i] = file_words[count_index + 3 + 3 * i];
			t = rec_tag[i][31:24];
			if (t < 1 || t > 5) begin
				$display("record %0d names a test that does not exist", i);
				stray_errors++;
			end else if (rec_tag[i][23:16] == 8'd2) begin
				store_q.push_back(i);
				remaining[t]++;
			end else if (rec_tag[i][23:16] == 8'd1 || rec_tag[i][23:16] == 8'd3) begin
				retire_q.push_back(i);
				remaining[t]++;
			end else begin
				$display("record %0d has an unknown kind", i);
				stray_errors++;
			end
		end
	endtask

	initial begin
		int cycles;
		int errors;
		clk = 1'b0;
		reset = 1'b1;
		stray_errors = 0;
		checks = 0;
		timeouts = 0;
		for (int t = 1; t <= 6; t++) begin
			remaining[t] = 0;
			test_errors[t] = 0;
		end
		void'($urandom(32'he694_16ab));
		for (int i = 0; i < 256; i++)
			ram[i] = {~i[7:0], i[7:0], 8'hc3, i[7:0]};
		// Load targets live in words 64 to 127
		for (int i = 64; i < 128; i++)
			ram[i] = $urandom;
		$readmemh("tests/program_input.mem", file_words);
		load_records();

		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			if (i == 2)
				reset <= 1'b0;
			if (i > 0)
				check_reset_state();
		end
		$display("test 6 %s: done, %0d errors", test_name(6), test_errors[6]);

		cycles = 0;
		while ((retire_q.size() > 0 || store_q.size() > 0) && cycles < 500) begin
			@(posedge clk);
			cycles++;
		end
		if (retire_q.size() > 0 || store_q.size() > 0) begin
			$display("timeout after %0d cycles, %0d retires and %0d stores never seen",
				cycles, retire_q.size(), store_q.size());
			timeouts++;
		end
		// Flushed slots must stay silent during the quiet period
		repeat (20) @(posedge clk);
		for (int t = 1; t <= 5; t++) begin
			if (remaining[t] > 0)
				$display("test %0d %s: incomplete, %0d records missing",
					t, test_name(t), remaining[t]);
		end

		errors = stray_errors + timeouts;
		for (int t = 1; t <= 6; t++)
			errors += test_errors[t];
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
